//--- fetch_settings.svh
/*
 * Widths, sizes and fixed addresses of the fetch subsystem.
 * FETCH_MEM_WORDS must equal 2**FETCH_MEM_IDX_W.
 * FETCH_QUEUE_DEPTH and FETCH_BTB_ENTRIES must be powers of two.
 * Fetches in [FETCH_PF_BASE, FETCH_PF_LIMIT) take a page fault.
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`define FETCH_PC_W        32
`define FETCH_INSTR_W     32
`define FETCH_MEM_IDX_W   8
`define FETCH_MEM_WORDS   256
`define FETCH_QUEUE_DEPTH 4
`define FETCH_BTB_ENTRIES 8
`define FETCH_RESET_ADDR  32'h0000_0000
`define FETCH_TRAP_ADDR   32'h0000_0100
`define FETCH_PF_BASE     32'h0000_0200
`define FETCH_PF_LIMIT    32'h0000_0280

`endif

//--- fetch_pkg.sv
/*
 * Shared types of the fetch subsystem.
 * Widths come from the settings header.
 */
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    // Instruction address and word
    typedef logic [`FETCH_PC_W-1:0]      pc_t;
    typedef logic [`FETCH_INSTR_W-1:0]   instr_t;

    // Word index into instruction memory
    typedef logic [`FETCH_MEM_IDX_W-1:0] mem_idx_t;

    // Next-PC source
    typedef enum logic [1:0] {
        KEEP      = 2'd0,
        BP_OR_PC4 = 2'd1,
        JUMP      = 2'd2
    } next_pc_sel_e;

    // Fetch exception causes, listed in priority order
    typedef enum logic [1:0] {
        MISALIGNED   = 2'd0,
        ACCESS_FAULT = 2'd1,
        PAGE_FAULT   = 2'd2
    } xcpt_cause_e;

endpackage

`default_nettype wire

//--- branch_predictor.sv
/*
 * Direct-mapped branch target buffer, full tags, 2-bit counters.
 * Lookup is combinational; training takes effect on the next edge.
 * A not-taken result only updates an entry that is already present.
 */
`default_nettype none

`include "fetch_settings.svh"

module branch_predictor (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  fetch_pkg::pc_t lookup_pc_i,
    input  logic           train_valid_i,
    input  fetch_pkg::pc_t train_pc_i,
    input  fetch_pkg::pc_t train_target_i,
    input  logic           train_taken_i,
    output logic           hit_o,
    output logic           taken_o,
    output fetch_pkg::pc_t target_o
);
    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    localparam int TAG_W = `FETCH_PC_W - IDX_W - 2;

    logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]              tag_q    [`FETCH_BTB_ENTRIES];
    fetch_pkg::pc_t                target_q [`FETCH_BTB_ENTRIES];
    logic [1:0]                    ctr_q    [`FETCH_BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_hit;

    // Word-aligned index, rest of the PC is the tag
    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign rd_tag = lookup_pc_i[`FETCH_PC_W-1:IDX_W+2];
    assign wr_idx = train_pc_i[IDX_W+1:2];
    assign wr_tag = train_pc_i[`FETCH_PC_W-1:IDX_W+2];
    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign taken_o  = ctr_q[rd_idx][1];
    assign target_o = target_q[rd_idx];

    // Only a taken result allocates
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (train_valid_i && train_taken_i && !wr_hit) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (train_valid_i) begin
            if (wr_hit && train_taken_i) begin
                // Saturate up, keep the latest target
                ctr_q[wr_idx]    <= (ctr_q[wr_idx] == 2'b11) ? 2'b11 : ctr_q[wr_idx] + 2'd1;
                target_q[wr_idx] <= train_target_i;
            end else if (wr_hit) begin
                ctr_q[wr_idx] <= (ctr_q[wr_idx] == 2'b00) ? 2'b00 : ctr_q[wr_idx] - 2'd1;
            end else if (train_taken_i) begin
                // New entry starts weakly taken
                tag_q[wr_idx]    <= wr_tag;
                target_q[wr_idx] <= train_target_i;
                ctr_q[wr_idx]    <= 2'b10;
            end
        end
    end

endmodule

`default_nettype wire

//--- instr_mem.sv
/*
 * Word-addressed instruction memory, combinational read.
 * Load port is meant for use while the core is in reset.
 * Address bits above the word index are ignored here.
 */
`default_nettype none

`include "fetch_settings.svh"

module instr_mem (
    input  logic                clk_i,
    input  logic                load_we_i,
    input  fetch_pkg::mem_idx_t load_idx_i,
    input  fetch_pkg::instr_t   load_data_i,
    input  fetch_pkg::pc_t      addr_i,
    output fetch_pkg::instr_t   data_o,
    output logic                page_fault_o
);
    fetch_pkg::instr_t   mem_q [`FETCH_MEM_WORDS];
    fetch_pkg::mem_idx_t rd_idx;

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem_q[load_idx_i] <= load_data_i;
        end
    end

    assign rd_idx = addr_i[`FETCH_MEM_IDX_W+1:2];
    assign data_o = mem_q[rd_idx];

    // Unmapped page window
    assign page_fault_o = (addr_i >= `FETCH_PF_BASE) && (addr_i < `FETCH_PF_LIMIT);

endmodule

`default_nettype wire

//--- if_stage.sv
/*
 * Fetch stage: PC register, next-PC select, exception check.
 * Memory and predictor answer in the same cycle as the PC.
 * First push happens one cycle after reset release.
 * Fetch carries on past exceptions; the consumer redirects.
 */
`default_nettype none

`include "fetch_settings.svh"

module if_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   stall_i,
    input  logic                   redirect_i,
    input  fetch_pkg::pc_t         redirect_pc_i,
    input  fetch_pkg::instr_t      mem_data_i,
    input  logic                   mem_page_fault_i,
    input  logic                   train_valid_i,
    input  fetch_pkg::pc_t         train_pc_i,
    input  fetch_pkg::pc_t         train_target_i,
    input  logic                   train_taken_i,
    output fetch_pkg::pc_t         mem_addr_o,
    output logic                   push_o,
    output fetch_pkg::pc_t         entry_pc_o,
    output fetch_pkg::instr_t      entry_instr_o,
    output logic                   entry_xcpt_valid_o,
    output fetch_pkg::xcpt_cause_e entry_xcpt_cause_o,
    output logic                   entry_pred_taken_o,
    output fetch_pkg::pc_t         entry_pred_target_o
);
    localparam fetch_pkg::pc_t MEM_BYTES = fetch_pkg::pc_t'(`FETCH_MEM_WORDS * 4);

    fetch_pkg::pc_t          pc_q;
    fetch_pkg::pc_t          next_pc;
    fetch_pkg::next_pc_sel_e next_sel;
    logic                    fetch_en_q;
    logic                    bp_hit;
    logic                    bp_taken;
    fetch_pkg::pc_t          bp_target;
    logic                    ex_misaligned;
    logic                    ex_access;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    // Redirect wins over stall
    always_comb begin
        if (redirect_i) begin
            next_sel = fetch_pkg::JUMP;
        end else if (stall_i || !fetch_en_q) begin
            next_sel = fetch_pkg::KEEP;
        end else begin
            next_sel = fetch_pkg::BP_OR_PC4;
        end
    end

    always_comb begin
        case (next_sel)
            fetch_pkg::KEEP:  next_pc = pc_q;
            fetch_pkg::JUMP:  next_pc = redirect_pc_i;
            default:          next_pc = (bp_hit && bp_taken) ? bp_target : pc_q + 32'd4;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= `FETCH_RESET_ADDR;
        end else begin
            pc_q <= next_pc;
        end
    end

    branch_predictor branch_predictor_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .lookup_pc_i    (pc_q),
        .train_valid_i  (train_valid_i),
        .train_pc_i     (train_pc_i),
        .train_target_i (train_target_i),
        .train_taken_i  (train_taken_i),
        .hit_o          (bp_hit),
        .taken_o        (bp_taken),
        .target_o       (bp_target)
    );

    assign ex_misaligned = |pc_q[1:0];
    assign ex_access     = pc_q >= MEM_BYTES;

    // Misaligned, then access fault, then page fault
    always_comb begin
        entry_xcpt_valid_o = ex_misaligned || ex_access || mem_page_fault_i;
        if (ex_misaligned) begin
            entry_xcpt_cause_o = fetch_pkg::MISALIGNED;
        end else if (ex_access) begin
            entry_xcpt_cause_o = fetch_pkg::ACCESS_FAULT;
        end else begin
            entry_xcpt_cause_o = fetch_pkg::PAGE_FAULT;
        end
    end

    assign mem_addr_o          = pc_q;
    // Wrong-path word in a redirect cycle is dropped
    assign push_o              = fetch_en_q && !stall_i && !redirect_i;
    assign entry_pc_o          = pc_q;
    assign entry_instr_o       = mem_data_i;
    assign entry_pred_taken_o  = bp_hit && bp_taken;
    assign entry_pred_target_o = bp_target;

endmodule

`default_nettype wire

//--- fetch_queue.sv
/*
 * FIFO of fetched entries between fetch and retire.
 * full_o doubles as the fetch stall, even with a pop in the same cycle.
 * Flush empties the queue and wins over push and pop.
 */
`default_nettype none

`include "fetch_settings.svh"

module fetch_queue (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  fetch_pkg::pc_t         entry_pc_i,
    input  fetch_pkg::instr_t      entry_instr_i,
    input  logic                   entry_xcpt_valid_i,
    input  fetch_pkg::xcpt_cause_e entry_xcpt_cause_i,
    input  logic                   entry_pred_taken_i,
    input  fetch_pkg::pc_t         entry_pred_target_i,
    input  logic                   pop_i,
    output fetch_pkg::pc_t         head_pc_o,
    output fetch_pkg::instr_t      head_instr_o,
    output logic                   head_xcpt_valid_o,
    output fetch_pkg::xcpt_cause_e head_xcpt_cause_o,
    output logic                   head_pred_taken_o,
    output fetch_pkg::pc_t         head_pred_target_o,
    output logic                   not_empty_o,
    output logic                   full_o
);
    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkg::pc_t         pc_q     [DEPTH];
    fetch_pkg::instr_t      instr_q  [DEPTH];
    logic                   xv_q     [DEPTH];
    fetch_pkg::xcpt_cause_e cause_q  [DEPTH];
    logic                   pt_q     [DEPTH];
    fetch_pkg::pc_t         ptgt_q   [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_q[wr_ptr_q]    <= entry_pc_i;
            instr_q[wr_ptr_q] <= entry_instr_i;
            xv_q[wr_ptr_q]    <= entry_xcpt_valid_i;
            cause_q[wr_ptr_q] <= entry_xcpt_cause_i;
            pt_q[wr_ptr_q]    <= entry_pred_taken_i;
            ptgt_q[wr_ptr_q]  <= entry_pred_target_i;
        end
    end

    assign head_pc_o          = pc_q[rd_ptr_q];
    assign head_instr_o       = instr_q[rd_ptr_q];
    assign head_xcpt_valid_o  = xv_q[rd_ptr_q];
    assign head_xcpt_cause_o  = cause_q[rd_ptr_q];
    assign head_pred_taken_o  = pt_q[rd_ptr_q];
    assign head_pred_target_o = ptgt_q[rd_ptr_q];
    assign not_empty_o        = count_q != '0;
    assign full_o             = count_q == CNT_W'(DEPTH);

    // Producer honours the stall, consumer checks occupancy
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> not_empty_o);

endmodule

`default_nettype wire

//--- jal_resolver.sv
/*
 * Retire stage standing in for the control unit.
 * Only JAL is decoded; every other word retires as sequential.
 * Redirect and training are combinational in the pop cycle.
 * Retire outputs follow the pop by one cycle.
 */
`default_nettype none

`include "fetch_settings.svh"

module jal_resolver (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   retire_ready_i,
    input  logic                   not_empty_i,
    input  fetch_pkg::pc_t         head_pc_i,
    input  fetch_pkg::instr_t      head_instr_i,
    input  logic                   head_xcpt_valid_i,
    input  fetch_pkg::xcpt_cause_e head_xcpt_cause_i,
    input  logic                   head_pred_taken_i,
    input  fetch_pkg::pc_t         head_pred_target_i,
    output logic                   pop_o,
    output logic                   redirect_o,
    output fetch_pkg::pc_t         redirect_pc_o,
    output logic                   train_valid_o,
    output fetch_pkg::pc_t         train_pc_o,
    output fetch_pkg::pc_t         train_target_o,
    output logic                   train_taken_o,
    output logic                   retire_valid_o,
    output fetch_pkg::pc_t         retire_pc_o,
    output fetch_pkg::instr_t      retire_instr_o,
    output logic                   xcpt_valid_o,
    output fetch_pkg::xcpt_cause_e xcpt_cause_o,
    output logic                   mispredict_o
);
    logic           is_jal;
    fetch_pkg::pc_t jal_imm;
    fetch_pkg::pc_t jal_target;
    logic           mispredict;
    logic           train_req;

    assign pop_o  = retire_ready_i && not_empty_i;
    assign is_jal = head_instr_i[6:0] == 7'b1101111;

    // J-type immediate, sign-extended
    assign jal_imm = {{11{head_instr_i[31]}}, head_instr_i[31], head_instr_i[19:12],
                      head_instr_i[20], head_instr_i[30:21], 1'b0};
    assign jal_target = head_pc_i + jal_imm;

    always_comb begin
        mispredict     = 1'b0;
        train_req      = 1'b0;
        train_taken_o  = 1'b0;
        redirect_pc_o  = head_pc_i + 32'd4;
        if (head_xcpt_valid_i) begin
            redirect_pc_o = `FETCH_TRAP_ADDR;
        end else if (is_jal) begin
            train_req     = 1'b1;
            train_taken_o = 1'b1;
            mispredict    = !head_pred_taken_i || (head_pred_target_i != jal_target);
            redirect_pc_o = jal_target;
        end else if (head_pred_taken_i) begin
            // Stale entry, fall through to PC+4
            train_req  = 1'b1;
            mispredict = 1'b1;
        end
    end

    assign redirect_o     = pop_o && (head_xcpt_valid_i || mispredict);
    assign train_valid_o  = pop_o && train_req;
    assign train_pc_o     = head_pc_i;
    assign train_target_o = jal_target;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            retire_valid_o <= 1'b0;
            xcpt_valid_o   <= 1'b0;
            mispredict_o   <= 1'b0;
        end else begin
            retire_valid_o <= pop_o;
            xcpt_valid_o   <= pop_o && head_xcpt_valid_i;
            mispredict_o   <= pop_o && mispredict;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            retire_pc_o    <= head_pc_i;
            retire_instr_o <= head_instr_i;
            xcpt_cause_o   <= head_xcpt_cause_i;
        end
    end

    // Flush leaves the queue empty, so no pop right after a redirect
    a_flush_drains: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_o |=> !pop_o);

endmodule

`default_nettype wire

//--- fetch_top.sv
/*
 * Fetch subsystem top: fetch stage, memory, queue, resolver.
 * Load the memory only while rstn_i is low.
 */
`default_nettype none

module fetch_top (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   load_we_i,
    input  fetch_pkg::mem_idx_t    load_idx_i,
    input  fetch_pkg::instr_t      load_data_i,
    input  logic                   retire_ready_i,
    output logic                   retire_valid_o,
    output fetch_pkg::pc_t         retire_pc_o,
    output fetch_pkg::instr_t      retire_instr_o,
    output logic                   xcpt_valid_o,
    output fetch_pkg::xcpt_cause_e xcpt_cause_o,
    output logic                   mispredict_o
);
    // Fetch to memory
    fetch_pkg::pc_t         mem_addr;
    fetch_pkg::instr_t      mem_data;
    logic                   mem_page_fault;

    // Fetch to queue
    logic                   push;
    logic                   stall;
    fetch_pkg::pc_t         in_pc;
    fetch_pkg::instr_t      in_instr;
    logic                   in_xcpt_valid;
    fetch_pkg::xcpt_cause_e in_xcpt_cause;
    logic                   in_pred_taken;
    fetch_pkg::pc_t         in_pred_target;

    // Queue head to resolver
    logic                   not_empty;
    logic                   pop;
    fetch_pkg::pc_t         hd_pc;
    fetch_pkg::instr_t      hd_instr;
    logic                   hd_xcpt_valid;
    fetch_pkg::xcpt_cause_e hd_xcpt_cause;
    logic                   hd_pred_taken;
    fetch_pkg::pc_t         hd_pred_target;

    // Resolver back to fetch
    logic                   redirect;
    fetch_pkg::pc_t         redirect_pc;
    logic                   train_valid;
    fetch_pkg::pc_t         train_pc;
    fetch_pkg::pc_t         train_target;
    logic                   train_taken;

    if_stage if_stage_i (
        .clk_i (clk_i), .rstn_i (rstn_i), .stall_i (stall),
        .redirect_i (redirect), .redirect_pc_i (redirect_pc),
        .mem_data_i (mem_data), .mem_page_fault_i (mem_page_fault),
        .train_valid_i (train_valid), .train_pc_i (train_pc),
        .train_target_i (train_target), .train_taken_i (train_taken),
        .mem_addr_o (mem_addr), .push_o (push),
        .entry_pc_o (in_pc), .entry_instr_o (in_instr),
        .entry_xcpt_valid_o (in_xcpt_valid), .entry_xcpt_cause_o (in_xcpt_cause),
        .entry_pred_taken_o (in_pred_taken), .entry_pred_target_o (in_pred_target)
    );

    instr_mem instr_mem_i (
        .clk_i (clk_i), .load_we_i (load_we_i), .load_idx_i (load_idx_i),
        .load_data_i (load_data_i), .addr_i (mem_addr),
        .data_o (mem_data), .page_fault_o (mem_page_fault)
    );

    // Redirect flushes the queue on the same edge
    fetch_queue fetch_queue_i (
        .clk_i (clk_i), .rstn_i (rstn_i), .flush_i (redirect), .push_i (push),
        .entry_pc_i (in_pc), .entry_instr_i (in_instr),
        .entry_xcpt_valid_i (in_xcpt_valid), .entry_xcpt_cause_i (in_xcpt_cause),
        .entry_pred_taken_i (in_pred_taken), .entry_pred_target_i (in_pred_target),
        .pop_i (pop), .head_pc_o (hd_pc), .head_instr_o (hd_instr),
        .head_xcpt_valid_o (hd_xcpt_valid), .head_xcpt_cause_o (hd_xcpt_cause),
        .head_pred_taken_o (hd_pred_taken), .head_pred_target_o (hd_pred_target),
        .not_empty_o (not_empty), .full_o (stall)
    );

    jal_resolver jal_resolver_i (
        .clk_i (clk_i), .rstn_i (rstn_i), .retire_ready_i (retire_ready_i),
        .not_empty_i (not_empty), .head_pc_i (hd_pc), .head_instr_i (hd_instr),
        .head_xcpt_valid_i (hd_xcpt_valid), .head_xcpt_cause_i (hd_xcpt_cause),
        .head_pred_taken_i (hd_pred_taken), .head_pred_target_i (hd_pred_target),
        .pop_o (pop), .redirect_o (redirect), .redirect_pc_o (redirect_pc),
        .train_valid_o (train_valid), .train_pc_o (train_pc),
        .train_target_o (train_target), .train_taken_o (train_taken),
        .retire_valid_o (retire_valid_o), .retire_pc_o (retire_pc_o),
        .retire_instr_o (retire_instr_o), .xcpt_valid_o (xcpt_valid_o),
        .xcpt_cause_o (xcpt_cause_o), .mispredict_o (mispredict_o)
    );

endmodule

`default_nettype wire

//--- tb_fetch_top.sv
/*
 * Testbench for the fetch subsystem.
 * Memory is reloaded under reset before each program.
 * Reference model follows retired PCs through shadow copies of each program.
 * Words fetched from a faulting PC are not compared.
 * Stops at the first mismatch.
 */
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int             WORDS       = `FETCH_MEM_WORDS;
    localparam fetch_pkg::pc_t LOOP_TOP    = 32'h0000_0060;
    localparam fetch_pkg::pc_t LOOP_JAL    = 32'h0000_0070;
    localparam fetch_pkg::pc_t TRAP_END    = `FETCH_TRAP_ADDR + 32'd8;
    localparam int             PHASE_LIMIT = 3000;

    logic                   clk_i;
    logic                   rstn_i;
    logic                   load_we_i;
    fetch_pkg::mem_idx_t    load_idx_i;
    fetch_pkg::instr_t      load_data_i;
    logic                   retire_ready_i;
    logic                   retire_valid_o;
    fetch_pkg::pc_t         retire_pc_o;
    fetch_pkg::instr_t      retire_instr_o;
    logic                   xcpt_valid_o;
    fetch_pkg::xcpt_cause_e xcpt_cause_o;
    logic                   mispredict_o;

    // Shadow of the loaded program
    fetch_pkg::instr_t shadow_mem [WORDS];
    logic              jal_at     [WORDS];
    fetch_pkg::pc_t    jal_dest   [WORDS];

    // Reference model state
    fetch_pkg::pc_t         exp_pc;
    logic                   exp_fault;
    fetch_pkg::xcpt_cause_e exp_cause;
    fetch_pkg::instr_t      exp_word;
    fetch_pkg::pc_t         watch_pc;
    int                     watch_hits;
    int                     watch_misses;
    int                     stall_cycles;

    // Ready generator state
    logic        rand_ready;
    logic [15:0] lfsr_state;
    int          hold_left;

    fetch_top fetch_top_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .load_we_i      (load_we_i),
        .load_idx_i     (load_idx_i),
        .load_data_i    (load_data_i),
        .retire_ready_i (retire_ready_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .xcpt_valid_o   (xcpt_valid_o),
        .xcpt_cause_o   (xcpt_cause_o),
        .mispredict_o   (mispredict_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    function automatic fetch_pkg::mem_idx_t word_of(input fetch_pkg::pc_t pc);
        return pc[`FETCH_MEM_IDX_W+1:2];
    endfunction

    // OP-IMM word stamped with its index, never a JAL
    function automatic fetch_pkg::instr_t filler_word(input int idx);
        logic [7:0] i8;
        i8 = idx[7:0];
        return {i8, ~i8, 9'd0, 7'b0010011};
    endfunction

    // jal x0 with the J-type immediate layout
    function automatic fetch_pkg::instr_t jal_word(input fetch_pkg::pc_t offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], 5'd0, 7'b1101111};
    endfunction

    // Fault rules in priority order
    function automatic logic faults(input fetch_pkg::pc_t pc);
        return (pc[1:0] != 2'b00) || (pc >= 32'(WORDS * 4))
            || ((pc >= `FETCH_PF_BASE) && (pc < `FETCH_PF_LIMIT));
    endfunction

    function automatic fetch_pkg::xcpt_cause_e cause_for(input fetch_pkg::pc_t pc);
        if (pc[1:0] != 2'b00) begin
            return fetch_pkg::MISALIGNED;
        end
        if (pc >= 32'(WORDS * 4)) begin
            return fetch_pkg::ACCESS_FAULT;
        end
        return fetch_pkg::PAGE_FAULT;
    endfunction

    function automatic fetch_pkg::pc_t next_expected(input fetch_pkg::pc_t pc);
        if (faults(pc)) begin
            return `FETCH_TRAP_ADDR;
        end
        if (jal_at[word_of(pc)]) begin
            return jal_dest[word_of(pc)];
        end
        return pc + 32'd4;
    endfunction

    always_comb begin
        exp_fault = faults(exp_pc);
        exp_cause = cause_for(exp_pc);
        exp_word  = shadow_mem[word_of(exp_pc)];
    end

    // Model steps once per retire
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exp_pc       <= `FETCH_RESET_ADDR;
            watch_hits   <= 0;
            watch_misses <= 0;
            stall_cycles <= 0;
        end else begin
            if (fetch_top_i.stall) begin
                stall_cycles <= stall_cycles + 1;
            end
            if (retire_valid_o) begin
                exp_pc <= next_expected(exp_pc);
                if (exp_pc == watch_pc) begin
                    watch_hits <= watch_hits + 1;
                    if (mispredict_o) begin
                        watch_misses <= watch_misses + 1;
                    end
                end
            end
        end
    end

    // Retire needs ready in the pop cycle before it
    a_ready_before_retire: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o |-> $past(retire_ready_i))
        else report_error("an entry retired although retire_ready_i was low at its pop");

    a_retire_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o |-> retire_pc_o == exp_pc)
        else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(exp_pc));

    a_retire_instr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o && !exp_fault |-> retire_instr_o == exp_word)
        else report_mismatch("retire_instr_o", $sampled(retire_instr_o), $sampled(exp_word));

    a_xcpt_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o |-> xcpt_valid_o == exp_fault)
        else report_mismatch("xcpt_valid_o", $sampled(xcpt_valid_o), $sampled(exp_fault));

    a_xcpt_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        retire_valid_o && exp_fault |-> xcpt_cause_o == exp_cause)
        else report_mismatch("xcpt_cause_o", 32'($sampled(xcpt_cause_o)),
                             32'($sampled(exp_cause)));

    // Galois LFSR, one step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
    endtask

    // Ready changes on the falling edge in random stretches
    initial begin
        int lvl;
        int len;
        lfsr_state     = 16'd18643;
        hold_left      = 0;
        retire_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (!rand_ready) begin
                retire_ready_i = 1'b1;
            end else if (hold_left > 0) begin
                hold_left = hold_left - 1;
            end else begin
                draw_bits(1, lvl);
                draw_bits(3, len);
                retire_ready_i = lvl[0];
                // Low stretches outlast the queue depth
                hold_left = lvl[0] ? len : len + `FETCH_QUEUE_DEPTH + 1;
            end
        end
    end

    task automatic fill_memory();
        for (int i = 0; i < WORDS; i++) begin
            shadow_mem[i] = filler_word(i);
            jal_at[i]     = 1'b0;
            jal_dest[i]   = '0;
        end
    endtask

    task automatic put_jal(input fetch_pkg::pc_t pc, input fetch_pkg::pc_t target);
        shadow_mem[word_of(pc)] = jal_word(target - pc);
        jal_at[word_of(pc)]     = 1'b1;
        jal_dest[word_of(pc)]   = target;
    endtask

    // Straight line to 0x20, forward JAL, loop closed at LOOP_JAL
    task automatic build_loop_program();
        fill_memory();
        put_jal(32'h0000_0020, LOOP_TOP);
        put_jal(LOOP_JAL, LOOP_TOP);
    endtask

    task automatic build_fault_program(input fetch_pkg::pc_t target);
        fill_memory();
        put_jal(`FETCH_RESET_ADDR, target);
    endtask

    task automatic start_reset();
        @(negedge clk_i);
        rstn_i = 1'b0;
    endtask

    // Load the shadow, then hold reset 4 more cycles
    task automatic load_and_release(input fetch_pkg::pc_t watch, input logic random);
        rand_ready = random;
        watch_pc   = watch;
        for (int i = 0; i < WORDS; i++) begin
            load_we_i   = 1'b1;
            load_idx_i  = fetch_pkg::mem_idx_t'(i);
            load_data_i = shadow_mem[i];
            @(negedge clk_i);
        end
        load_we_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;
    endtask

    task automatic wait_retired(input int n);
        int cycles;
        cycles = 0;
        while (watch_hits < n) begin
            @(negedge clk_i);
            cycles = cycles + 1;
            if (cycles > PHASE_LIMIT) begin
                report_error($sformatf("timeout waiting for PC %h to retire %0d times",
                                       watch_pc, n));
            end
        end
    endtask

    task automatic run_fault_case(input fetch_pkg::pc_t target);
        start_reset();
        build_fault_program(target);
        load_and_release(TRAP_END, 1'b0);
        wait_retired(1);
    endtask

    initial begin
        rstn_i      = 1'b0;
        load_we_i   = 1'b0;
        load_idx_i  = '0;
        load_data_i = '0;
        rand_ready  = 1'b0;
        watch_pc    = LOOP_JAL;

        // Sequential start, forward JAL, six loop turns
        // Predictor is empty after reset, so only the first turn mispredicts
        start_reset();
        build_loop_program();
        load_and_release(LOOP_JAL, 1'b0);
        wait_retired(6);
        assert (watch_misses == 1)
            else report_error("loop JAL did not mispredict exactly once with ready high");

        // Misaligned, beyond memory, page-fault window
        run_fault_case(32'h0000_000A);
        run_fault_case(32'(WORDS * 4));
        run_fault_case(`FETCH_PF_BASE);

        // Same loop under random back-pressure
        start_reset();
        build_loop_program();
        load_and_release(LOOP_JAL, 1'b1);
        wait_retired(6);
        assert (watch_misses == 1)
            else report_error("loop JAL did not mispredict exactly once under back-pressure");
        assert (stall_cycles > 0)
            else report_error("queue never filled while retire_ready_i was low");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.f
+incdir+.
fetch_pkg.sv
branch_predictor.sv
instr_mem.sv
if_stage.sv
fetch_queue.sv
jal_resolver.sv
fetch_top.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - branch_predictor.sv
      - instr_mem.sv
      - if_stage.sv
      - fetch_queue.sv
      - jal_resolver.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fetch_top.sv
